//--- verilog/chan_pkg.sv
// shared widths, sample types and beat structs for the channelizer input stage
package chan_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int FFT_SIZE_WIDTH = 12;
    localparam int ADDR_WIDTH     = 10;
    localparam int RAM_LATENCY    = 3;
    localparam int FIFO_DEPTH     = 16;
    // leaves room for reads still in the ram pipeline
    localparam int FIFO_AF_LEVEL  = 8;

    typedef logic [DATA_WIDTH-1:0]     sample_t;
    typedef logic [FFT_SIZE_WIDTH-1:0] fft_size_t;
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [FFT_SIZE_WIDTH-2:0] phase_t;

    // counted input sample on its way to the bank write
    typedef struct packed {
        sample_t sample;
        addr_t   pos;
        logic    last;
    } in_beat_t;

    // bank read result on its way to the output fifo
    typedef struct packed {
        sample_t sample;
        logic    start;
    } rd_beat_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_BANK0,
        RD_BANK1
    } rd_state_e;

endpackage

//--- verilog/sample_counter.sv
// input register stage of input_buffer, tags each accepted sample with its block position
`timescale 1ns/1ns

module sample_counter (
    input  logic                clk,
    input  logic                sync_reset,
    input  logic                s_tvalid,
    input  chan_pkg::sample_t   s_tdata,
    output logic                s_tready,
    input  chan_pkg::fft_size_t fft_size,
    output chan_pkg::in_beat_t  beat,
    output logic                beat_valid,
    input  logic                beat_ready
);

    chan_pkg::addr_t last_pos;
    chan_pkg::addr_t pos;
    logic            run;
    logic            accept;

    // M/2-1, M stays fixed once out of reset
    assign last_pos = chan_pkg::addr_t'(fft_size[chan_pkg::FFT_SIZE_WIDTH-1:1] - 1'b1);

    // holding register empty or draining this cycle
    assign s_tready = run && (!beat_valid || beat_ready);
    assign accept   = s_tvalid && s_tready;

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            run        <= 1'b0;
            beat_valid <= 1'b0;
            pos        <= '0;
        end else begin
            run <= 1'b1;
            if (accept) begin
                beat_valid <= 1'b1;
                if (pos == last_pos) begin
                    pos <= '0;
                end else begin
                    pos <= pos + 1'b1;
                end
            end else if (beat_ready) begin
                beat_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            beat.sample <= s_tdata;
            beat.pos    <= pos;
            beat.last   <= (pos == last_pos);
        end
    end

endmodule

//--- verilog/dp_ram.sv
// one ping-pong bank of input_buffer, read-first dual-port ram with three clocks of read latency
`timescale 1ns/1ns

module dp_ram (
    input  logic              clk,
    input  logic              wr_en,
    input  chan_pkg::addr_t   wr_addr,
    input  chan_pkg::sample_t wr_data,
    input  chan_pkg::addr_t   rd_addr,
    output chan_pkg::sample_t rd_data
);

    chan_pkg::sample_t mem [2**chan_pkg::ADDR_WIDTH];
    chan_pkg::addr_t   rd_addr_q;
    chan_pkg::sample_t mem_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // address reg, array read, output reg
    // a write on the same edge as the array read gives the old word
    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;
        mem_q     <= mem[rd_addr_q];
        rd_data   <= mem_q;
    end

endmodule

//--- verilog/phase_fifo.sv
// output fifo of input_buffer, buffers bank reads and tags each output with its phase
`timescale 1ns/1ns

module phase_fifo (
    input  logic                clk,
    input  logic                sync_reset,
    input  chan_pkg::fft_size_t fft_size,
    input  logic                push,
    input  chan_pkg::rd_beat_t  push_beat,
    output logic                almost_full,
    output logic                m_tvalid,
    output chan_pkg::sample_t   m_tdata,
    output logic                m_final,
    output chan_pkg::phase_t    m_phase,
    input  logic                m_tready
);

    chan_pkg::rd_beat_t                          mem [chan_pkg::FIFO_DEPTH];
    logic [$clog2(chan_pkg::FIFO_DEPTH)-1:0]     wr_ptr;
    logic [$clog2(chan_pkg::FIFO_DEPTH)-1:0]     rd_ptr;
    logic [$clog2(chan_pkg::FIFO_DEPTH+1)-1:0]   count;
    logic [$clog2(chan_pkg::FIFO_DEPTH+1)-1:0]   count_next;
    chan_pkg::rd_beat_t                          head;
    chan_pkg::phase_t                            phase_cnt;
    chan_pkg::phase_t                            cur_phase;
    chan_pkg::phase_t                            last_phase;
    logic                                        pop;

    assign last_phase = chan_pkg::phase_t'(fft_size - 1'b1);

    assign head     = mem[rd_ptr];
    assign m_tvalid = (count != '0);
    assign m_tdata  = head.sample;
    assign pop      = m_tvalid && m_tready;

    // block start realigns the phase to zero
    assign cur_phase = head.start ? '0 : phase_cnt;
    assign m_phase   = cur_phase;
    assign m_final   = m_tvalid && (cur_phase == last_phase);

    always_comb begin
        count_next = count;
        case ({push, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
            phase_cnt   <= '0;
        end else begin
            count       <= count_next;
            almost_full <= (count_next >= chan_pkg::FIFO_AF_LEVEL);
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (cur_phase == last_phase) begin
                    phase_cnt <= '0;
                end else begin
                    phase_cnt <= cur_phase + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/input_buffer.sv
// top of the M/2 channelizer input stage, ping-pong reversal buffer with a double-pass read
`timescale 1ns/1ns

module input_buffer (
    input  logic                clk,
    input  logic                sync_reset,
    input  logic                s_tvalid,
    input  chan_pkg::sample_t   s_tdata,
    output logic                s_tready,
    input  chan_pkg::fft_size_t fft_size,
    output logic                m_tvalid,
    output chan_pkg::sample_t   m_tdata,
    output logic                m_final,
    output chan_pkg::phase_t    m_phase,
    input  logic                m_tready
);

    chan_pkg::addr_t     last_pos;

    // write side
    chan_pkg::in_beat_t  beat;
    logic                beat_valid;
    logic                beat_ready;
    logic                wr_fire;
    logic                wr_bank;
    logic [1:0]          full;
    logic [1:0]          we_q;
    chan_pkg::addr_t     wr_addr_q;
    chan_pkg::sample_t   wr_data_q;

    // read side
    chan_pkg::rd_state_e state;
    logic                rd_next;
    logic                sec_pass;
    chan_pkg::addr_t     rd_ptr;
    logic                rd_issue;
    logic                rd_wrap;
    logic                rd_done;
    logic                rd_cur_bank;
    logic                rd_en;
    logic                rd_sel_q;
    logic                rd_start_q;
    chan_pkg::addr_t     rd_addr;
    chan_pkg::sample_t   rd_data0;
    chan_pkg::sample_t   rd_data1;

    // return path
    logic [chan_pkg::RAM_LATENCY-1:0] rd_en_d;
    logic [chan_pkg::RAM_LATENCY-1:0] rd_sel_d;
    logic [chan_pkg::RAM_LATENCY-1:0] rd_start_d;
    logic                             ret_valid;
    chan_pkg::rd_beat_t               ret_beat;
    logic                             almost_full;

    assign last_pos = chan_pkg::addr_t'(fft_size[chan_pkg::FFT_SIZE_WIDTH-1:1] - 1'b1);

    sample_counter u_sample_counter (
        .clk        (clk),
        .sync_reset (sync_reset),
        .s_tvalid   (s_tvalid),
        .s_tdata    (s_tdata),
        .s_tready   (s_tready),
        .fft_size   (fft_size),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready)
    );

    // hold off while the bank being written still waits to be read out
    assign beat_ready = !full[wr_bank];
    assign wr_fire    = beat_valid && beat_ready;

    assign rd_cur_bank = (state == chan_pkg::RD_BANK1);
    assign rd_issue    = (state != chan_pkg::RD_IDLE) && !almost_full;
    assign rd_wrap     = (rd_ptr == last_pos);
    assign rd_done     = rd_issue && rd_wrap && sec_pass;

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            wr_bank <= 1'b0;
            full    <= 2'b00;
            we_q    <= 2'b00;
        end else begin
            we_q <= {wr_fire && wr_bank, wr_fire && !wr_bank};
            if (wr_fire && beat.last) begin
                wr_bank       <= !wr_bank;
                full[wr_bank] <= 1'b1;
            end
            // never the bank being written, that one is not full
            if (rd_done) begin
                full[rd_cur_bank] <= 1'b0;
            end
        end
    end

    // reversed order within the block
    always_ff @(posedge clk) begin
        wr_addr_q <= last_pos - beat.pos;
        wr_data_q <= beat.sample;
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            state    <= chan_pkg::RD_IDLE;
            rd_next  <= 1'b0;
            sec_pass <= 1'b0;
            rd_ptr   <= '0;
            rd_en    <= 1'b0;
        end else begin
            rd_en <= rd_issue;
            case (state)
                chan_pkg::RD_IDLE: begin
                    rd_ptr   <= '0;
                    sec_pass <= 1'b0;
                    if (full[rd_next]) begin
                        state <= rd_next ? chan_pkg::RD_BANK1 : chan_pkg::RD_BANK0;
                    end
                end
                default: begin
                    // stall keeps rd_ptr and sec_pass as they are
                    if (rd_issue) begin
                        if (rd_wrap) begin
                            rd_ptr   <= '0;
                            sec_pass <= 1'b1;
                            if (sec_pass) begin
                                state   <= chan_pkg::RD_IDLE;
                                rd_next <= !rd_next;
                            end
                        end else begin
                            rd_ptr <= rd_ptr + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            rd_addr <= rd_ptr;
        end
        rd_sel_q   <= rd_cur_bank;
        rd_start_q <= (rd_ptr == '0) && !sec_pass;
    end

    dp_ram u_bank0 (
        .clk     (clk),
        .wr_en   (we_q[0]),
        .wr_addr (wr_addr_q),
        .wr_data (wr_data_q),
        .rd_addr (rd_addr),
        .rd_data (rd_data0)
    );

    dp_ram u_bank1 (
        .clk     (clk),
        .wr_en   (we_q[1]),
        .wr_addr (wr_addr_q),
        .wr_data (wr_data_q),
        .rd_addr (rd_addr),
        .rd_data (rd_data1)
    );

    // line up read tags with the ram output
    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            rd_en_d   <= '0;
            ret_valid <= 1'b0;
        end else begin
            rd_en_d   <= {rd_en_d[chan_pkg::RAM_LATENCY-2:0], rd_en};
            ret_valid <= rd_en_d[chan_pkg::RAM_LATENCY-1];
        end
    end

    always_ff @(posedge clk) begin
        rd_sel_d   <= {rd_sel_d[chan_pkg::RAM_LATENCY-2:0], rd_sel_q};
        rd_start_d <= {rd_start_d[chan_pkg::RAM_LATENCY-2:0], rd_start_q};
        ret_beat.sample <= rd_sel_d[chan_pkg::RAM_LATENCY-1] ? rd_data1 : rd_data0;
        ret_beat.start  <= rd_start_d[chan_pkg::RAM_LATENCY-1];
    end

    phase_fifo u_phase_fifo (
        .clk         (clk),
        .sync_reset  (sync_reset),
        .fft_size    (fft_size),
        .push        (ret_valid),
        .push_beat   (ret_beat),
        .almost_full (almost_full),
        .m_tvalid    (m_tvalid),
        .m_tdata     (m_tdata),
        .m_final     (m_final),
        .m_phase     (m_phase),
        .m_tready    (m_tready)
    );

endmodule

//--- testbench/tb_lfsr.svh
// random bit source for tb_input_buffer, included inside the testbench module

logic [15:0] lfsr_state = 16'd43;

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_step()};
    end
    return v;
endfunction

//--- testbench/tb_input_buffer.sv
// testbench for input_buffer that checks random traffic against a reversal and phase model
`timescale 1ns/1ns

module tb_input_buffer;

    `include "tb_lfsr.svh"

    localparam int TIMEOUT_CYCLES = 60000;

    logic                clk;
    logic                sync_reset;
    logic                s_tvalid;
    chan_pkg::sample_t   s_tdata;
    logic                s_tready;
    chan_pkg::fft_size_t fft_size;
    logic                m_tvalid;
    chan_pkg::sample_t   m_tdata;
    logic                m_final;
    chan_pkg::phase_t    m_phase;
    logic                m_tready;

    int                errors;
    int                test_errors_start;
    int                tests_run;
    int                tests_failed;
    int                cur_m;
    int                in_left;
    int                out_count;
    bit                in_taken;
    bit                stall_blocked;
    bit                aborted;
    chan_pkg::sample_t blk_q[$];
    chan_pkg::sample_t exp_data_q[$];
    int                exp_phase_q[$];

    input_buffer u_input_buffer (
        .clk        (clk),
        .sync_reset (sync_reset),
        .s_tvalid   (s_tvalid),
        .s_tdata    (s_tdata),
        .s_tready   (s_tready),
        .fft_size   (fft_size),
        .m_tvalid   (m_tvalid),
        .m_tdata    (m_tdata),
        .m_final    (m_final),
        .m_phase    (m_phase),
        .m_tready   (m_tready)
    );

    always #5 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic finish_run();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_errors_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors_start);
        end
        test_errors_start = errors;
    endtask

    task automatic apply_reset(input int m);
        @(negedge clk);
        sync_reset = 1'b1;
        fft_size   = chan_pkg::fft_size_t'(m);
        s_tvalid   = 1'b0;
        m_tready   = 1'b0;
        in_taken   = 1'b0;
        cur_m      = m;
        blk_q.delete();
        exp_data_q.delete();
        exp_phase_q.delete();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            compare_value("m_tvalid", m_tvalid, 0);
            compare_value("m_final", m_final, 0);
            compare_value("s_tready", s_tready, 0);
        end
        sync_reset = 1'b0;
        #1;
        compare_value("m_tvalid", m_tvalid, 0);
        compare_value("m_final", m_final, 0);
    endtask

    task automatic wait_input_ready();
        int n;
        n = 0;
        while (s_tready !== 1'b1 && !aborted) begin
            if (n == 10) begin
                report_error("s_tready did not rise after reset release");
                aborted = 1'b1;
            end else begin
                @(negedge clk);
                #1;
                n++;
            end
        end
    endtask

    // a full block goes out reversed, twice, with phases 0 to M-1
    task automatic model_input(input chan_pkg::sample_t d);
        blk_q.push_back(d);
        if (blk_q.size() == cur_m / 2) begin
            for (int p = 0; p < 2; p++) begin
                for (int i = cur_m / 2 - 1; i >= 0; i--) begin
                    exp_data_q.push_back(blk_q[i]);
                    exp_phase_q.push_back(p * cur_m / 2 + (cur_m / 2 - 1 - i));
                end
            end
            blk_q.delete();
        end
    endtask

    task automatic check_output();
        chan_pkg::sample_t exp_d;
        int                exp_p;
        out_count++;
        if (exp_data_q.size() == 0) begin
            report_error("output beat with no expected sample");
        end else begin
            exp_d = exp_data_q.pop_front();
            exp_p = exp_phase_q.pop_front();
            compare_value("m_tdata", m_tdata, exp_d);
            compare_value("m_phase", m_phase, exp_p);
            compare_value("m_final", m_final, exp_p == cur_m - 1);
        end
    endtask

    // drive after the falling edge, then look at what the next rising edge transfers
    task automatic cycle_step(input bit rand_valid, input bit rand_ready, input bit stall);
        @(negedge clk);
        if (!s_tvalid || in_taken) begin
            if (in_left > 0 && (!rand_valid || rand_bits(2) != 0)) begin
                s_tvalid = 1'b1;
                s_tdata  = rand_bits(32);
            end else begin
                s_tvalid = 1'b0;
            end
        end
        m_tready = stall ? 1'b0 : (!rand_ready || rand_bits(2) != 0);
        #1;
        in_taken = s_tvalid && s_tready;
        if (in_taken) begin
            model_input(s_tdata);
            in_left--;
        end
        if (m_tvalid && m_tready) begin
            check_output();
        end
    endtask

    task automatic run_traffic(input int blocks, input bit rand_valid, input bit rand_ready,
                               input int stall_at, input int stall_len);
        int c;
        int idle;
        bit stall;
        c = 0;
        idle = 0;
        in_left = blocks * cur_m / 2;
        out_count = 0;
        stall_blocked = 1'b0;
        // a few quiet cycles after draining catch stray outputs
        while (idle < 20 && !aborted) begin
            stall = (c >= stall_at) && (c < stall_at + stall_len);
            cycle_step(rand_valid, rand_ready, stall);
            if (stall && c == stall_at + stall_len - 1) begin
                stall_blocked = !s_tready;
            end
            if (in_left == 0 && exp_data_q.size() == 0 && blk_q.size() == 0) begin
                idle++;
            end
            c++;
            if (c == TIMEOUT_CYCLES) begin
                report_error("traffic did not drain before the cycle limit");
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            compare_value("output count", out_count, blocks * cur_m);
        end
    endtask

    initial begin
        errors = 0;
        test_errors_start = 0;
        tests_run = 0;
        tests_failed = 0;
        aborted = 1'b0;
        clk = 1'b0;
        sync_reset = 1'b1;
        s_tvalid = 1'b0;
        s_tdata = '0;
        fft_size = chan_pkg::fft_size_t'(16);
        m_tready = 1'b0;
        in_taken = 1'b0;
        in_left = 0;
        cur_m = 16;

        apply_reset(16);
        wait_input_ready();
        report_test("reset state");

        if (!aborted) begin
            run_traffic(4, 1'b0, 1'b0, 0, 0);
            report_test("reversal and double pass, M=16");
        end

        if (!aborted) begin
            apply_reset(8);
            wait_input_ready();
            run_traffic(6, 1'b1, 1'b0, 0, 0);
            report_test("random input gaps, M=8");
        end

        if (!aborted) begin
            apply_reset(32);
            wait_input_ready();
            run_traffic(8, 1'b1, 1'b1, 60, 400);
            if (!aborted && !stall_blocked) begin
                report_error("s_tready still high at the end of the long output stall");
            end
            report_test("output back-pressure, M=32");
        end

        if (!aborted) begin
            apply_reset(2048);
            wait_input_ready();
            run_traffic(2, 1'b1, 1'b1, 0, 0);
            report_test("size change, M=2048");
        end

        finish_run();
    end

endmodule

//--- input_buffer.f
+incdir+testbench
verilog/chan_pkg.sv
verilog/sample_counter.sv
verilog/dp_ram.sv
verilog/phase_fifo.sv
verilog/input_buffer.sv
testbench/tb_input_buffer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the input_buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -Wno-fatal -j 0 --top-module tb_input_buffer \
    -f input_buffer.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
